//--- src/openadc_pkg.sv
package openadc_pkg;

   // datapath and register widths
   localparam int ADC_WIDTH       = 12;
   localparam int REG_WIDTH       = 8;
   localparam int LEVEL_HI_WIDTH  = ADC_WIDTH - REG_WIDTH;  // level bits in the high register
   localparam int HEARTBEAT_WIDTH = 26;
   localparam int PWM_WIDTH       = 8;                      // accumulator is one bit wider

   // register map
   localparam logic [REG_WIDTH-1:0] ADDR_GAIN          = 8'd0;
   localparam logic [REG_WIDTH-1:0] ADDR_SETTINGS      = 8'd1;
   localparam logic [REG_WIDTH-1:0] ADDR_TRIG_LEVEL_LO = 8'd2;
   localparam logic [REG_WIDTH-1:0] ADDR_TRIG_LEVEL_HI = 8'd3;
   localparam logic [REG_WIDTH-1:0] ADDR_STATUS        = 8'd4;  // read only

   // settings fields
   localparam int SETTINGS_ARM_BIT    = 0;
   localparam int SETTINGS_SOURCE_BIT = 1;   // 1 = adc, 0 = test counter
   localparam int SETTINGS_LED_LSB    = 2;
   localparam int LED_SELECT_WIDTH    = 2;

   // status fields
   localparam int STATUS_ARMED_BIT     = 0;
   localparam int STATUS_TRIGGERED_BIT = 1;

   typedef enum logic [LED_SELECT_WIDTH-1:0] {
      LED_STATUS    = 2'd0,
      LED_HEARTBEAT = 2'd1,
      LED_SLOW      = 2'd2,
      LED_OFF       = 2'd3
   } led_mode_t;

   // heartbeat timer taps
   localparam int HB_LED_A_BIT = 24;
   localparam int HB_LED_B_BIT = 23;
   localparam int HB_SLOW_BIT  = 25;

   // register reset values
   localparam logic [PWM_WIDTH-1:0] GAIN_RESET       = '0;
   localparam logic [REG_WIDTH-1:0] SETTINGS_RESET   = '0;
   localparam logic [ADC_WIDTH-1:0] TRIG_LEVEL_RESET = '0;

endpackage

//--- src/openadc_cfg_if.sv
interface openadc_cfg_if;

   logic [openadc_pkg::PWM_WIDTH-1:0] gain;
   openadc_pkg::led_mode_t            led_select;
   logic                              arm;
   logic                              data_source_select;
   logic [openadc_pkg::ADC_WIDTH-1:0] trigger_level;
   logic                              triggered;   // single-shot latch from the trigger

   modport regs (
      output gain,
      output led_select,
      output arm,
      output data_source_select,
      output trigger_level,
      input  triggered
   );

   modport sample (
      input data_source_select
   );

   modport trigger (
      output triggered,
      input  arm,
      input  trigger_level
   );

   modport led (
      input led_select,
      input arm,
      input triggered
   );

endinterface

//--- src/reg_openadc.sv
module reg_openadc (
   input  logic                              clk_usb,
   input  logic                              reset,
   input  logic [openadc_pkg::REG_WIDTH-1:0] reg_address_i,
   input  logic [openadc_pkg::REG_WIDTH-1:0] reg_datai_i,
   input  logic                              reg_write_i,
   input  logic                              reg_read_i,
   output logic [openadc_pkg::REG_WIDTH-1:0] reg_datao_o,
   openadc_cfg_if.regs                       cfg
);

   logic [openadc_pkg::PWM_WIDTH-1:0]      gain_r;
   logic [openadc_pkg::REG_WIDTH-1:0]      settings_r;
   logic [openadc_pkg::REG_WIDTH-1:0]      trig_level_lo_r;
   logic [openadc_pkg::LEVEL_HI_WIDTH-1:0] trig_level_hi_r;
   logic [openadc_pkg::REG_WIDTH-1:0]      status;
   logic [openadc_pkg::REG_WIDTH-1:0]      read_value;

   // write decode
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_r          <= openadc_pkg::GAIN_RESET;
         settings_r      <= openadc_pkg::SETTINGS_RESET;
         trig_level_lo_r <= openadc_pkg::TRIG_LEVEL_RESET[openadc_pkg::REG_WIDTH-1:0];
         trig_level_hi_r <= openadc_pkg::TRIG_LEVEL_RESET[openadc_pkg::ADC_WIDTH-1:
                                                          openadc_pkg::REG_WIDTH];
      end
      else if (reg_write_i) begin
         case (reg_address_i)
            openadc_pkg::ADDR_GAIN: begin
               gain_r <= reg_datai_i[openadc_pkg::PWM_WIDTH-1:0];
            end
            openadc_pkg::ADDR_SETTINGS: begin
               settings_r <= reg_datai_i;
            end
            openadc_pkg::ADDR_TRIG_LEVEL_LO: begin
               trig_level_lo_r <= reg_datai_i;
            end
            openadc_pkg::ADDR_TRIG_LEVEL_HI: begin
               trig_level_hi_r <= reg_datai_i[openadc_pkg::LEVEL_HI_WIDTH-1:0]; // low nibble
            end
            default: begin
               // status and unmapped addresses ignore writes
            end
         endcase
      end
   end

   always_comb begin
      status = '0;
      status[openadc_pkg::STATUS_ARMED_BIT]     = settings_r[openadc_pkg::SETTINGS_ARM_BIT];
      status[openadc_pkg::STATUS_TRIGGERED_BIT] = cfg.triggered;
   end

   always_comb begin
      case (reg_address_i)
         openadc_pkg::ADDR_GAIN:          read_value = gain_r;
         openadc_pkg::ADDR_SETTINGS:      read_value = settings_r;
         openadc_pkg::ADDR_TRIG_LEVEL_LO: read_value = trig_level_lo_r;
         openadc_pkg::ADDR_TRIG_LEVEL_HI: begin
            read_value = {{(openadc_pkg::REG_WIDTH - openadc_pkg::LEVEL_HI_WIDTH){1'b0}},
                          trig_level_hi_r};
         end
         openadc_pkg::ADDR_STATUS:        read_value = status;
         default:                         read_value = '0;
      endcase
   end

   // data out only valid the cycle after a read strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         reg_datao_o <= '0;
      end
      else if (reg_read_i) begin
         reg_datao_o <= read_value;
      end
      else begin
         reg_datao_o <= '0;
      end
   end

   assign cfg.gain               = gain_r;
   assign cfg.arm                = settings_r[openadc_pkg::SETTINGS_ARM_BIT];
   assign cfg.data_source_select = settings_r[openadc_pkg::SETTINGS_SOURCE_BIT];
   assign cfg.led_select         = openadc_pkg::led_mode_t'(
      settings_r[openadc_pkg::SETTINGS_LED_LSB +: openadc_pkg::LED_SELECT_WIDTH]);
   assign cfg.trigger_level      = {trig_level_hi_r, trig_level_lo_r};

endmodule

//--- src/adc_sample_path.sv
module adc_sample_path (
   input  logic                              clk_usb,
   input  logic                              reset,
   input  logic [openadc_pkg::ADC_WIDTH-1:0] adc_data_i,
   openadc_cfg_if.sample                     cfg,
   output logic [openadc_pkg::ADC_WIDTH-1:0] sample_o
);

   logic [openadc_pkg::ADC_WIDTH-1:0] test_counter;
   logic [openadc_pkg::ADC_WIDTH-1:0] sample_pre_r;
   logic [openadc_pkg::ADC_WIDTH-1:0] sample_r;

   // free-running ramp, wraps naturally
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         test_counter <= '0;
      end
      else begin
         test_counter <= test_counter + 1'b1;
      end
   end

   // two resample stages between the pins and the trigger
   always_ff @(posedge clk_usb) begin
      sample_pre_r <= cfg.data_source_select ? adc_data_i : test_counter;
      sample_r     <= sample_pre_r;
   end

   assign sample_o = sample_r;

endmodule

//--- src/adc_level_trigger.sv
module adc_level_trigger (
   input  logic                              clk_usb,
   input  logic                              reset,
   input  logic [openadc_pkg::ADC_WIDTH-1:0] sample_i,
   input  logic                              adc_trigger_active_i,
   openadc_cfg_if.trigger                    cfg,
   output logic                              trigger_adc_o
);

   logic armed_r;       // arm delayed one cycle
   logic triggered_r;
   logic level_met;
   logic arm_rise;

   // level msb picks the direction: set = above, clear = below
   always_comb begin
      if (cfg.trigger_level[openadc_pkg::ADC_WIDTH-1]) begin
         level_met = sample_i > cfg.trigger_level;
      end
      else begin
         level_met = sample_i < cfg.trigger_level;
      end
   end

   assign arm_rise = cfg.arm && !armed_r;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_r       <= 1'b0;
         trigger_adc_o <= 1'b0;
         triggered_r   <= 1'b0;
      end
      else begin
         armed_r       <= cfg.arm;
         // latch is not set yet in the pulse cycle
         trigger_adc_o <= !triggered_r && !trigger_adc_o && adc_trigger_active_i
                          && armed_r && level_met;

         // one shot per arm
         if (trigger_adc_o) begin
            triggered_r <= 1'b1;
         end
         else if (arm_rise) begin
            triggered_r <= 1'b0;
         end
      end
   end

   assign cfg.triggered = triggered_r;

endmodule

//--- src/heartbeat_led.sv
module heartbeat_led (
   input  logic       clk_usb,
   input  logic       reset,
   openadc_cfg_if.led cfg,
   output logic       led_armed_o,
   output logic       led_capture_o
);

   logic [openadc_pkg::HEARTBEAT_WIDTH-1:0] timer_r;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_r <= '0;
      end
      else begin
         timer_r <= timer_r + 1'b1;
      end
   end

   // led source mux
   always_comb begin
      case (cfg.led_select)
         openadc_pkg::LED_STATUS: begin
            led_armed_o   = cfg.arm;
            led_capture_o = cfg.triggered;
         end
         openadc_pkg::LED_HEARTBEAT: begin
            led_armed_o   = timer_r[openadc_pkg::HB_LED_A_BIT];
            led_capture_o = timer_r[openadc_pkg::HB_LED_B_BIT];
         end
         openadc_pkg::LED_SLOW: begin
            led_armed_o   = timer_r[openadc_pkg::HB_SLOW_BIT];   // both blink together
            led_capture_o = timer_r[openadc_pkg::HB_SLOW_BIT];
         end
         default: begin
            led_armed_o   = 1'b0;
            led_capture_o = 1'b0;
         end
      endcase
   end

endmodule

//--- src/openadc_interface.sv
module openadc_interface (
   input  logic                              clk_usb,
   input  logic                              reset,
   input  logic [openadc_pkg::REG_WIDTH-1:0] reg_address_i,
   input  logic [openadc_pkg::REG_WIDTH-1:0] reg_datai_i,
   input  logic                              reg_write_i,
   input  logic                              reg_read_i,
   output logic [openadc_pkg::REG_WIDTH-1:0] reg_datao_o,
   input  logic [openadc_pkg::ADC_WIDTH-1:0] adc_data_i,
   input  logic                              adc_trigger_active_i,
   output logic                              trigger_adc_o,
   output logic                              armed_and_ready_o,
   output logic                              led_armed_o,
   output logic                              led_capture_o,
   output logic                              amp_gain_o
);

   openadc_cfg_if cfg ();

   logic [openadc_pkg::ADC_WIDTH-1:0] sample;
   logic [openadc_pkg::PWM_WIDTH:0]   pwm_accumulator;

   reg_openadc u_reg_openadc (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_datai_i   (reg_datai_i),
      .reg_write_i   (reg_write_i),
      .reg_read_i    (reg_read_i),
      .reg_datao_o   (reg_datao_o),
      .cfg           (cfg.regs)
   );

   adc_sample_path u_adc_sample_path (
      .clk_usb    (clk_usb),
      .reset      (reset),
      .adc_data_i (adc_data_i),
      .cfg        (cfg.sample),
      .sample_o   (sample)
   );

   adc_level_trigger u_adc_level_trigger (
      .clk_usb              (clk_usb),
      .reset                (reset),
      .sample_i             (sample),
      .adc_trigger_active_i (adc_trigger_active_i),
      .cfg                  (cfg.trigger),
      .trigger_adc_o        (trigger_adc_o)
   );

   heartbeat_led u_heartbeat_led (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .cfg           (cfg.led),
      .led_armed_o   (led_armed_o),
      .led_capture_o (led_capture_o)
   );

   // gain pwm: carry out of a modulo-256 accumulator
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         pwm_accumulator <= '0;
      end
      else begin
         pwm_accumulator <= {1'b0, pwm_accumulator[openadc_pkg::PWM_WIDTH-1:0]}
                            + {1'b0, cfg.gain};
      end
   end

   assign amp_gain_o        = pwm_accumulator[openadc_pkg::PWM_WIDTH];
   assign armed_and_ready_o = cfg.arm;   // software arm drives the sequencer directly

endmodule

//--- verification/openadc_interface_checker.sv
module openadc_interface_checker (
   input logic clk_usb,
   input logic reset,
   input logic armed_r,
   input logic trigger_adc_o
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned failures = 0;   // read by the testbench at the end of the run

   // a trigger pulse lasts exactly one cycle
   single_cycle_pulse: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_adc_o |=> !trigger_adc_o)
      else begin
         failures++;
         $error("trigger_adc_o high on two consecutive cycles");
      end

   // no pulse while the delayed arm is low
   pulse_needs_arm: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_adc_o |-> armed_r)
      else begin
         failures++;
         $error("trigger_adc_o high without armed_r");
      end

   quiet_in_reset: assert property (@(posedge clk_usb) reset |=> !trigger_adc_o)
      else begin
         failures++;
         $error("trigger_adc_o high during reset");
      end

endmodule

bind adc_level_trigger openadc_interface_checker u_level_trigger_checker (
   .clk_usb       (clk_usb),
   .reset         (reset),
   .armed_r       (armed_r),
   .trigger_adc_o (trigger_adc_o)
);

//--- verification/openadc_interface_tb.sv
module openadc_interface_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_CYCLES  = 20000;   // tests need roughly 5500 cycles
   localparam int HOLD_CYCLES = 8;
   localparam int CNT_WAIT    = 4200;    // one full counter ramp plus margin

   logic                              clk_usb;
   logic                              reset;
   logic [openadc_pkg::REG_WIDTH-1:0] reg_address_i;
   logic [openadc_pkg::REG_WIDTH-1:0] reg_datai_i;
   logic                              reg_write_i;
   logic                              reg_read_i;
   logic [openadc_pkg::REG_WIDTH-1:0] reg_datao_o;
   logic [openadc_pkg::ADC_WIDTH-1:0] adc_data_i;
   logic                              adc_trigger_active_i;
   logic                              trigger_adc_o;
   logic                              armed_and_ready_o;
   logic                              led_armed_o;
   logic                              led_capture_o;
   logic                              amp_gain_o;

   logic [31:0] lfsr_state      = 32'h88a4;
   int          error_count     = 0;
   int          check_count     = 0;
   int          observed_pulses = 0;
   int          expected_pulses = 0;
   int          cycle_count     = 0;
   event        case_done;

   openadc_interface u_openadc_interface (
      .clk_usb              (clk_usb),
      .reset                (reset),
      .reg_address_i        (reg_address_i),
      .reg_datai_i          (reg_datai_i),
      .reg_write_i          (reg_write_i),
      .reg_read_i           (reg_read_i),
      .reg_datao_o          (reg_datao_o),
      .adc_data_i           (adc_data_i),
      .adc_trigger_active_i (adc_trigger_active_i),
      .trigger_adc_o        (trigger_adc_o),
      .armed_and_ready_o    (armed_and_ready_o),
      .led_armed_o          (led_armed_o),
      .led_capture_o        (led_capture_o),
      .amp_gain_o           (amp_gain_o)
   );

   initial begin
      clk_usb = 1'b0;
      forever #20 clk_usb = ~clk_usb;
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         value      = {value[30:0], fb};
      end
      return value;
   endfunction

   // msb of the level set means fire above, clear means fire below
   function automatic logic trigger_expected(input logic [11:0] sample, input logic [11:0] level);
      if (level[11]) begin
         return sample > level;
      end
      return sample < level;
   endfunction

   function automatic logic [7:0] settings_value(input logic arm, input logic adc_source,
                                                 input openadc_pkg::led_mode_t led);
      logic [7:0] value;
      value = '0;
      value[openadc_pkg::SETTINGS_ARM_BIT]    = arm;
      value[openadc_pkg::SETTINGS_SOURCE_BIT] = adc_source;
      value[openadc_pkg::SETTINGS_LED_LSB +: openadc_pkg::LED_SELECT_WIDTH] = led;
      return value;
   endfunction

   always @(posedge clk_usb) begin
      if (!reset && trigger_adc_o) begin
         observed_pulses++;
      end
   end

   // pulse count compare at the end of each trigger case
   always @(case_done) begin
      check_count++;
      if (observed_pulses != expected_pulses) begin
         $display("FAILED at %0t ns: %0d trigger pulses, expected %0d",
                  $time, observed_pulses, expected_pulses);
         error_count++;
      end
   end

   // tasks start and return on a falling edge
   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      reg_address_i = addr;
      reg_datai_i   = data;
      reg_write_i   = 1'b1;
      @(negedge clk_usb);
      reg_write_i = 1'b0;
   endtask

   task automatic check_value(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
         error_count++;
      end
   endtask

   task automatic check_read(input string what, input logic [7:0] addr,
                             input logic [7:0] expected);
      reg_address_i = addr;
      reg_read_i    = 1'b1;
      @(negedge clk_usb);
      reg_read_i = 1'b0;
      check_value(what, reg_datao_o, expected);
   endtask

   task automatic finish_case();
      -> case_done;
      @(negedge clk_usb);
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         $display("test %s: ok", name);
      end
      else begin
         $display("test %s: %0d errors", name, error_count - errors_before);
      end
   endtask

   task automatic run_level_case(input logic [11:0] sample, input logic [11:0] level);
      logic expect_hit;
      expect_hit = trigger_expected(sample, level);
      adc_data_i = sample;
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_LO, level[7:0]);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_HI, {4'h0, level[11:8]});
      write_reg(openadc_pkg::ADDR_SETTINGS, settings_value(1'b1, 1'b1, openadc_pkg::LED_STATUS));
      repeat (HOLD_CYCLES) @(negedge clk_usb);
      if (expect_hit) begin
         expected_pulses++;
      end
      finish_case();
      check_read("status", openadc_pkg::ADDR_STATUS, {6'd0, expect_hit, 1'b1});  // triggered, armed
      write_reg(openadc_pkg::ADDR_SETTINGS, settings_value(1'b0, 1'b1, openadc_pkg::LED_STATUS));
   endtask

   task automatic rearm(input logic adc_source);
      write_reg(openadc_pkg::ADDR_SETTINGS,
                settings_value(1'b0, adc_source, openadc_pkg::LED_STATUS));
      write_reg(openadc_pkg::ADDR_SETTINGS,
                settings_value(1'b1, adc_source, openadc_pkg::LED_STATUS));
   endtask

   task automatic check_leds_dark(input openadc_pkg::led_mode_t mode);
      write_reg(openadc_pkg::ADDR_SETTINGS, settings_value(1'b0, 1'b0, mode));
      check_value("led_armed_o", led_armed_o, 0);
      check_value("led_capture_o", led_capture_o, 0);
   endtask

   initial begin
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk_usb);
         cycle_count++;
      end
      $display("timeout: no result after %0d clock cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      logic [31:0] rnd;
      logic [11:0] sample;
      logic [7:0]  gain;
      int          ones;
      int          start_pulses;
      int          waited;
      int          errors_before;
      int          assert_failures;

      reset                = 1'b1;
      reg_address_i        = '0;
      reg_datai_i          = '0;
      reg_write_i          = 1'b0;
      reg_read_i           = 1'b0;
      adc_data_i           = '0;
      adc_trigger_active_i = 1'b1;
      repeat (2) @(negedge clk_usb);
      reset = 1'b0;

      errors_before = error_count;
      write_reg(openadc_pkg::ADDR_GAIN, 8'ha5);
      check_read("gain", openadc_pkg::ADDR_GAIN, 8'ha5);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_LO, 8'h5a);
      check_read("level lo", openadc_pkg::ADDR_TRIG_LEVEL_LO, 8'h5a);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_HI, 8'hf3);
      check_read("level hi", openadc_pkg::ADDR_TRIG_LEVEL_HI, 8'h03);  // low nibble only
      write_reg(openadc_pkg::ADDR_SETTINGS, 8'hfe);
      check_read("settings", openadc_pkg::ADDR_SETTINGS, 8'hfe);
      check_read("status idle", openadc_pkg::ADDR_STATUS, 8'h00);
      // level 0 below mode never fires
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_LO, 8'h00);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_HI, 8'h00);
      write_reg(openadc_pkg::ADDR_SETTINGS, 8'h01);
      check_read("status armed", openadc_pkg::ADDR_STATUS, 8'h01);
      check_value("armed_and_ready_o", armed_and_ready_o, 1);
      check_read("unknown address", 8'h7f, 8'h00);
      write_reg(openadc_pkg::ADDR_SETTINGS, 8'h00);
      report_test("register readback", errors_before);

      errors_before = error_count;
      for (int i = 0; i < 4; i++) begin
         rnd  = random_bits(8);
         gain = rnd[7:0];
         write_reg(openadc_pkg::ADDR_GAIN, gain);
         repeat (2) @(negedge clk_usb);
         ones = 0;
         repeat (256) begin
            @(negedge clk_usb);
            if (amp_gain_o) begin
               ones++;
            end
         end
         check_value("pwm high cycles", ones, gain);
      end
      report_test("pwm duty", errors_before);

      errors_before = error_count;
      for (int i = 0; i < 8; i++) begin
         rnd    = random_bits(12);
         sample = rnd[11:0];
         rnd    = random_bits(12);
         run_level_case(sample, rnd[11:0]);
      end
      report_test("level trigger", errors_before);

      errors_before = error_count;
      adc_data_i = 12'h000;   // always below 12'h100
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_LO, 8'h00);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_HI, 8'h01);
      rearm(1'b1);
      repeat (20) @(negedge clk_usb);
      expected_pulses++;
      finish_case();
      rearm(1'b1);
      repeat (20) @(negedge clk_usb);
      expected_pulses++;
      finish_case();
      adc_trigger_active_i = 1'b0;
      rearm(1'b1);
      repeat (20) @(negedge clk_usb);
      finish_case();
      write_reg(openadc_pkg::ADDR_SETTINGS, settings_value(1'b0, 1'b1, openadc_pkg::LED_STATUS));
      repeat (2) @(negedge clk_usb);   // let armed_r drop first
      adc_trigger_active_i = 1'b1;
      report_test("single shot", errors_before);

      errors_before = error_count;
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_LO, 8'h00);
      write_reg(openadc_pkg::ADDR_TRIG_LEVEL_HI, 8'h09);
      write_reg(openadc_pkg::ADDR_SETTINGS, settings_value(1'b1, 1'b0, openadc_pkg::LED_STATUS));
      start_pulses = observed_pulses;
      waited       = 0;
      while (observed_pulses == start_pulses && waited < CNT_WAIT) begin
         @(negedge clk_usb);
         waited++;
      end
      expected_pulses++;
      finish_case();
      report_test("test counter", errors_before);

      errors_before = error_count;
      check_value("led_armed_o", led_armed_o, 1);
      check_value("led_capture_o", led_capture_o, 1);
      write_reg(openadc_pkg::ADDR_SETTINGS, settings_value(1'b0, 1'b0, openadc_pkg::LED_STATUS));
      check_value("led_armed_o", led_armed_o, 0);
      check_value("led_capture_o", led_capture_o, 1);   // latch holds after disarm
      check_value("armed_and_ready_o", armed_and_ready_o, 0);
      check_leds_dark(openadc_pkg::LED_HEARTBEAT);
      check_leds_dark(openadc_pkg::LED_SLOW);
      check_leds_dark(openadc_pkg::LED_OFF);
      report_test("leds", errors_before);

      assert_failures = u_openadc_interface.u_adc_level_trigger.u_level_trigger_checker.failures;
      if (assert_failures != 0) begin
         $display("level trigger checker saw %0d assertion failures", assert_failures);
         error_count += assert_failures;
      end
      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end
      else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- flist.f
src/openadc_pkg.sv
src/openadc_cfg_if.sv
src/reg_openadc.sv
src/adc_sample_path.sv
src/adc_level_trigger.sv
src/heartbeat_led.sv
src/openadc_interface.sv
verification/openadc_interface_checker.sv
verification/openadc_interface_tb.sv
